// ==== rtl/u3v_pkg.sv ====
`default_nettype none

package u3v_pkg;

	// ------------------------------
	// section states of the frame controller
	// ------------------------------
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		LEADER  = 3'd1,
		IMAGE   = 3'd2,
		CHUNK   = 3'd3,
		TRAILER = 3'd4,
		SKIP    = 3'd5
	} fmt_state_e;

	// apb register offsets
	typedef enum logic [7:0] {
		CTRL         = 8'h00,
		PIXEL_FORMAT = 8'h04,
		BLOCK_ID     = 8'h08
	} reg_addr_e;

	// ctrl register layout
	localparam int STREAM_EN_BIT  = 0;
	localparam int ACQ_START_BIT  = 1;
	localparam int CHUNK_MODE_BIT = 2;
	localparam int FID_EN_BIT     = 3;
	localparam int TS_EN_BIT      = 4;
	localparam int CTRL_WD        = 5;

	// ------------------------------
	// magic words, "U3VL" and "U3VT" read little endian
	localparam logic [31:0] LEADER_MAGIC  = 32'h4C56_3355;
	localparam logic [31:0] TRAILER_MAGIC = 32'h5456_3355;

	// section lengths in words and bytes
	localparam int          LEADER_WORDS  = 6;
	localparam int          TRAILER_WORDS = 4;
	localparam logic [15:0] LEADER_BYTES  = 16'd24;
	localparam logic [15:0] TRAILER_BYTES = 16'd16;

	// ------------------------------
	// chunk ids and layout
	localparam logic [31:0] CHUNK_ID_IMAGE  = 32'd1;
	localparam logic [31:0] CHUNK_ID_FID    = 32'd2;
	localparam logic [31:0] CHUNK_ID_TS     = 32'd3;
	// image chunk is id plus byte count
	localparam int          CHUNK_IMG_WORDS = 2;
	// fid and ts chunks are two data words, id, length
	localparam int          CHUNK_TAG_WORDS = 4;
	localparam logic [31:0] CHUNK_TAG_BYTES = 32'd8;

endpackage

`default_nettype wire

// ==== rtl/u3v_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module u3v_apb_regs #(
	parameter int BID_WD = 32
) (
	input  wire               clk,
	input  wire               i_rst_n,
	// apb slave
	input  wire               i_psel,
	input  wire               i_penable,
	input  wire               i_pwrite,
	input  wire  [7:0]        i_paddr,
	input  wire  [31:0]       i_pwdata,
	output logic [31:0]       o_prdata,
	output logic              o_pready,
	output logic              o_pslverr,
	// current block id, read only
	input  wire  [BID_WD-1:0] i_block_id,
	// configuration out
	output logic              o_stream_enable,
	output logic              o_acq_start,
	output logic              o_chunk_mode,
	output logic              o_fid_en,
	output logic              o_ts_en,
	output logic [31:0]       o_pixel_format
);

	logic [u3v_pkg::CTRL_WD-1:0] ctrl_q;
	logic [31:0]                 pix_fmt_q;
	logic                        access;
	logic                        addr_hit;
	logic                        wr_ok;

	// ------------------------------
	// decode
	// ------------------------------
	// access phase of a selected transfer
	assign access = i_psel & i_penable;

	always_comb begin
		case (i_paddr)
			u3v_pkg::CTRL,
			u3v_pkg::PIXEL_FORMAT,
			u3v_pkg::BLOCK_ID: addr_hit = 1'b1;
			default:           addr_hit = 1'b0;
		endcase
	end

	// unknown offset or write to the read-only block id
	assign o_pslverr = access & (~addr_hit | (i_pwrite & (i_paddr == u3v_pkg::BLOCK_ID)));
	assign wr_ok     = access & i_pwrite & ~o_pslverr;

	// zero wait states
	assign o_pready = 1'b1;

	// ------------------------------
	// registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			ctrl_q    <= '0;
			pix_fmt_q <= '0;
		end else if (wr_ok) begin
			case (i_paddr)
				u3v_pkg::CTRL:         ctrl_q    <= i_pwdata[u3v_pkg::CTRL_WD-1:0];
				u3v_pkg::PIXEL_FORMAT: pix_fmt_q <= i_pwdata;
				default:               ;
			endcase
		end
	end

	// read mux, block id comes straight from the header generator
	always_comb begin
		case (i_paddr)
			u3v_pkg::CTRL:         o_prdata = 32'(ctrl_q);
			u3v_pkg::PIXEL_FORMAT: o_prdata = pix_fmt_q;
			u3v_pkg::BLOCK_ID:     o_prdata = 32'(i_block_id);
			default:               o_prdata = 32'h0;
		endcase
	end

	// control bits out
	assign o_stream_enable = ctrl_q[u3v_pkg::STREAM_EN_BIT];
	assign o_acq_start     = ctrl_q[u3v_pkg::ACQ_START_BIT];
	assign o_chunk_mode    = ctrl_q[u3v_pkg::CHUNK_MODE_BIT];
	assign o_fid_en        = ctrl_q[u3v_pkg::FID_EN_BIT];
	assign o_ts_en         = ctrl_q[u3v_pkg::TS_EN_BIT];
	assign o_pixel_format  = pix_fmt_q;

endmodule

`default_nettype wire

// ==== rtl/u3v_header_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module u3v_header_gen #(
	parameter int TS_WD  = 64,
	parameter int BID_WD = 32,
	parameter int IDX_WD = 4
) (
	input  wire               clk,
	input  wire               i_rst_n,
	// frame events from the controller
	input  wire               i_frame_start,
	input  wire               i_frame_done,
	input  wire               i_image_word,
	input  wire  [IDX_WD-1:0] i_chunk_words,
	// sampled at frame start
	input  wire  [TS_WD-1:0]  i_timestamp,
	input  wire  [31:0]       i_pixel_format,
	// word indices
	input  wire  [IDX_WD-1:0] i_leader_idx,
	input  wire  [IDX_WD-1:0] i_trailer_idx,
	output logic [31:0]       o_leader_word,
	output logic [31:0]       o_trailer_word,
	output logic [BID_WD-1:0] o_block_id,
	output logic [TS_WD-1:0]  o_ts_latched
);

	logic [BID_WD-1:0] bid_q;
	logic [29:0]       img_words_q;
	logic [TS_WD-1:0]  ts_q;
	logic [31:0]       pix_fmt_q;
	logic [63:0]       ts_ext;
	logic [31:0]       payload_bytes;

	// ------------------------------
	// block id and image word count
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			bid_q       <= '0;
			img_words_q <= '0;
		end else begin
			// next block after the last trailer word
			if (i_frame_done)
				bid_q <= bid_q + 1'b1;
			if (i_frame_start)
				img_words_q <= '0;
			else if (i_image_word)
				img_words_q <= img_words_q + 1'b1;
		end
	end

	// per-frame snapshot of timestamp and format
	always_ff @(posedge clk) begin
		if (i_frame_start) begin
			ts_q      <= i_timestamp;
			pix_fmt_q <= i_pixel_format;
		end
	end

	// 32-bit timestamps read back with a zero high word
	assign ts_ext = 64'(ts_q);

	// image bytes plus chunk bytes
	assign payload_bytes = {img_words_q, 2'b00} + 32'({i_chunk_words, 2'b00});

	// ------------------------------
	// leader and trailer words by index
	// ------------------------------
	always_comb begin
		case (int'(i_leader_idx))
			0:       o_leader_word = u3v_pkg::LEADER_MAGIC;
			1:       o_leader_word = {16'h0, u3v_pkg::LEADER_BYTES};
			2:       o_leader_word = 32'(bid_q);
			3:       o_leader_word = ts_ext[31:0];
			4:       o_leader_word = ts_ext[63:32];
			default: o_leader_word = pix_fmt_q;
		endcase
	end

	always_comb begin
		case (int'(i_trailer_idx))
			0:       o_trailer_word = u3v_pkg::TRAILER_MAGIC;
			1:       o_trailer_word = {16'h0, u3v_pkg::TRAILER_BYTES};
			2:       o_trailer_word = 32'(bid_q);
			default: o_trailer_word = payload_bytes;
		endcase
	end

	assign o_block_id   = bid_q;
	assign o_ts_latched = ts_q;

endmodule

`default_nettype wire

// ==== rtl/u3v_chunk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module u3v_chunk_gen #(
	parameter int TS_WD  = 64,
	parameter int BID_WD = 32,
	parameter int IDX_WD = 4
) (
	input  wire               clk,
	input  wire               i_rst_n,
	input  wire               i_frame_start,
	input  wire               i_image_word,
	// chunk enables, sampled at frame start
	input  wire               i_chunk_mode,
	input  wire               i_fid_en,
	input  wire               i_ts_en,
	// chunk payloads from the header generator
	input  wire  [BID_WD-1:0] i_block_id,
	input  wire  [TS_WD-1:0]  i_ts_latched,
	input  wire  [IDX_WD-1:0] i_chunk_idx,
	output logic [31:0]       o_chunk_word,
	output logic [IDX_WD-1:0] o_chunk_words
);

	logic        mode_q;
	logic        fid_q;
	logic        ts_q;
	logic [31:0] img_bytes_q;
	logic [63:0] ts_ext;
	int          chunk_len;
	int          tag_idx;
	int          ts_idx;

	// ------------------------------
	// frame snapshot and byte count
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			mode_q      <= 1'b0;
			fid_q       <= 1'b0;
			ts_q        <= 1'b0;
			img_bytes_q <= '0;
		end else if (i_frame_start) begin
			mode_q      <= i_chunk_mode;
			fid_q       <= i_fid_en;
			ts_q        <= i_ts_en;
			img_bytes_q <= '0;
		end else if (i_image_word) begin
			img_bytes_q <= img_bytes_q + 32'd4;
		end
	end

	// chunk section length, 0 / 2 / 6 / 10 words
	always_comb begin
		chunk_len = 0;
		if (mode_q) begin
			chunk_len = u3v_pkg::CHUNK_IMG_WORDS;
			if (fid_q)
				chunk_len = chunk_len + u3v_pkg::CHUNK_TAG_WORDS;
			if (ts_q)
				chunk_len = chunk_len + u3v_pkg::CHUNK_TAG_WORDS;
		end
	end

	assign o_chunk_words = IDX_WD'(chunk_len);
	assign ts_ext        = 64'(i_ts_latched);

	// ------------------------------
	// index to word
	// ------------------------------
	always_comb begin
		tag_idx = int'(i_chunk_idx) - u3v_pkg::CHUNK_IMG_WORDS;
		// ts chunk follows the fid chunk when both are on
		ts_idx  = fid_q ? tag_idx - u3v_pkg::CHUNK_TAG_WORDS : tag_idx;
		if (tag_idx < 0) begin
			o_chunk_word = (tag_idx == -2) ? u3v_pkg::CHUNK_ID_IMAGE : img_bytes_q;
		end else if (fid_q && tag_idx < u3v_pkg::CHUNK_TAG_WORDS) begin
			case (tag_idx)
				0:       o_chunk_word = 32'(i_block_id);
				1:       o_chunk_word = 32'h0;
				2:       o_chunk_word = u3v_pkg::CHUNK_ID_FID;
				default: o_chunk_word = u3v_pkg::CHUNK_TAG_BYTES;
			endcase
		end else begin
			case (ts_idx)
				0:       o_chunk_word = ts_ext[31:0];
				1:       o_chunk_word = ts_ext[63:32];
				2:       o_chunk_word = u3v_pkg::CHUNK_ID_TS;
				default: o_chunk_word = u3v_pkg::CHUNK_TAG_BYTES;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/u3v_frame_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module u3v_frame_ctrl #(
	parameter int IDX_WD = 4
) (
	input  wire                 clk,
	input  wire                 i_rst_n,
	// camera stream
	input  wire                 i_fval,
	input  wire                 i_data_valid,
	input  wire  [31:0]         i_data,
	input  wire                 i_stream_enable,
	input  wire                 i_acq_start,
	// generator words
	input  wire  [31:0]         i_leader_word,
	input  wire  [31:0]         i_trailer_word,
	input  wire  [31:0]         i_chunk_word,
	input  wire  [IDX_WD-1:0]   i_chunk_words,
	// events and indices to the generators
	output logic                o_frame_start,
	output logic                o_frame_done,
	output logic                o_image_word,
	output logic [IDX_WD-1:0]   o_leader_idx,
	output logic [IDX_WD-1:0]   o_trailer_idx,
	output logic [IDX_WD-1:0]   o_chunk_idx,
	output u3v_pkg::fmt_state_e o_state,
	// formatted stream
	output logic                o_fval,
	output logic                o_data_valid,
	output logic                o_leader_flag,
	output logic                o_image_flag,
	output logic                o_chunk_flag,
	output logic                o_trailer_flag,
	output logic [31:0]         o_data
);

	localparam logic [IDX_WD-1:0] LEADER_LAST  = IDX_WD'(u3v_pkg::LEADER_WORDS - 1);
	localparam logic [IDX_WD-1:0] TRAILER_LAST = IDX_WD'(u3v_pkg::TRAILER_WORDS - 1);

	u3v_pkg::fmt_state_e state;
	u3v_pkg::fmt_state_e state_nxt;
	logic                fval_d;
	logic [IDX_WD-1:0]   leader_idx;
	logic [IDX_WD-1:0]   trailer_idx;
	logic [IDX_WD-1:0]   chunk_idx;
	logic                sel_leader;
	logic                sel_image;
	logic                sel_chunk;
	logic                sel_trailer;
	logic [31:0]         sel_data;

	// ------------------------------
	// frame events
	// ------------------------------
	assign o_frame_start = (state == u3v_pkg::IDLE) & i_fval & ~fval_d
		& i_stream_enable & i_acq_start;
	assign o_frame_done  = (state == u3v_pkg::TRAILER) & (trailer_idx == TRAILER_LAST);
	assign o_image_word  = (state == u3v_pkg::IMAGE) & i_fval & i_data_valid;

	// ------------------------------
	// next state and word select
	// ------------------------------
	always_comb begin
		state_nxt   = state;
		sel_leader  = 1'b0;
		sel_image   = 1'b0;
		sel_chunk   = 1'b0;
		sel_trailer = 1'b0;
		case (state)
			u3v_pkg::IDLE: begin
				// disabled frames are swallowed whole
				if (o_frame_start)
					state_nxt = u3v_pkg::LEADER;
				else if (i_fval & ~fval_d)
					state_nxt = u3v_pkg::SKIP;
			end
			u3v_pkg::LEADER: begin
				sel_leader = 1'b1;
				if (leader_idx == LEADER_LAST)
					state_nxt = u3v_pkg::IMAGE;
			end
			u3v_pkg::IMAGE: begin
				// fval low, first chunk or trailer word goes out now
				if (!i_fval) begin
					if (i_chunk_words != '0) begin
						sel_chunk = 1'b1;
						state_nxt = u3v_pkg::CHUNK;
					end else begin
						sel_trailer = 1'b1;
						state_nxt   = u3v_pkg::TRAILER;
					end
				end else begin
					sel_image = i_data_valid;
				end
			end
			u3v_pkg::CHUNK: begin
				sel_chunk = 1'b1;
				if (chunk_idx == i_chunk_words - 1'b1)
					state_nxt = u3v_pkg::TRAILER;
			end
			u3v_pkg::TRAILER: begin
				sel_trailer = 1'b1;
				if (o_frame_done)
					state_nxt = u3v_pkg::IDLE;
			end
			u3v_pkg::SKIP: begin
				if (!i_fval)
					state_nxt = u3v_pkg::IDLE;
			end
			default: state_nxt = u3v_pkg::IDLE;
		endcase
	end

	// output data mux
	always_comb begin
		if (sel_leader)
			sel_data = i_leader_word;
		else if (sel_chunk)
			sel_data = i_chunk_word;
		else if (sel_trailer)
			sel_data = i_trailer_word;
		else
			sel_data = i_data;
	end

	// ------------------------------
	// state, indices, output stage
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state          <= u3v_pkg::IDLE;
			fval_d         <= 1'b0;
			leader_idx     <= '0;
			trailer_idx    <= '0;
			chunk_idx      <= '0;
			o_fval         <= 1'b0;
			o_data_valid   <= 1'b0;
			o_leader_flag  <= 1'b0;
			o_image_flag   <= 1'b0;
			o_chunk_flag   <= 1'b0;
			o_trailer_flag <= 1'b0;
		end else begin
			state  <= state_nxt;
			fval_d <= i_fval;
			if (o_frame_start) begin
				leader_idx  <= '0;
				trailer_idx <= '0;
				chunk_idx   <= '0;
			end else begin
				if (sel_leader)
					leader_idx <= leader_idx + 1'b1;
				if (sel_chunk)
					chunk_idx <= chunk_idx + 1'b1;
				if (sel_trailer)
					trailer_idx <= trailer_idx + 1'b1;
			end
			// o_fval spans start pulse through last trailer word
			o_fval         <= o_frame_start
				| ((state != u3v_pkg::IDLE) & (state != u3v_pkg::SKIP));
			o_data_valid   <= sel_leader | sel_image | sel_chunk | sel_trailer;
			o_leader_flag  <= sel_leader;
			o_image_flag   <= sel_image;
			o_chunk_flag   <= sel_chunk;
			o_trailer_flag <= sel_trailer;
		end
	end

	// payload stage
	always_ff @(posedge clk) begin
		o_data <= sel_data;
	end

	assign o_leader_idx  = leader_idx;
	assign o_trailer_idx = trailer_idx;
	assign o_chunk_idx   = chunk_idx;
	assign o_state       = state;

endmodule

`default_nettype wire

// ==== rtl/u3v_format_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module u3v_format_top #(
	parameter int TS_WD  = 64,
	parameter int BID_WD = 32,
	parameter int IDX_WD = 4
) (
	input  wire              clk,
	input  wire              i_rst_n,
	// apb
	input  wire              i_psel,
	input  wire              i_penable,
	input  wire              i_pwrite,
	input  wire  [7:0]       i_paddr,
	input  wire  [31:0]      i_pwdata,
	output logic [31:0]      o_prdata,
	output logic             o_pready,
	output logic             o_pslverr,
	// camera stream
	input  wire              i_fval,
	input  wire              i_data_valid,
	input  wire  [31:0]      i_data,
	input  wire  [TS_WD-1:0] i_timestamp,
	// u3v stream
	output logic             o_fval,
	output logic             o_data_valid,
	output logic             o_leader_flag,
	output logic             o_image_flag,
	output logic             o_chunk_flag,
	output logic             o_trailer_flag,
	output logic [31:0]      o_data
);

	// configuration
	logic stream_enable, acq_start, chunk_mode, fid_en, ts_en;
	logic [31:0] pixel_format;
	// controller to generators
	logic frame_start, frame_done, image_word;
	logic [IDX_WD-1:0] leader_idx, trailer_idx, chunk_idx, chunk_words;
	logic [31:0] leader_word, trailer_word, chunk_word;
	logic [BID_WD-1:0] block_id;
	logic [TS_WD-1:0] ts_latched;
	u3v_pkg::fmt_state_e fmt_state;

	u3v_apb_regs #(.BID_WD(BID_WD)) u_regs (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.i_block_id(block_id),
		.o_stream_enable(stream_enable), .o_acq_start(acq_start),
		.o_chunk_mode(chunk_mode), .o_fid_en(fid_en), .o_ts_en(ts_en),
		.o_pixel_format(pixel_format)
	);

	u3v_header_gen #(.TS_WD(TS_WD), .BID_WD(BID_WD), .IDX_WD(IDX_WD)) u_header (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_frame_start(frame_start), .i_frame_done(frame_done),
		.i_image_word(image_word), .i_chunk_words(chunk_words),
		.i_timestamp(i_timestamp), .i_pixel_format(pixel_format),
		.i_leader_idx(leader_idx), .i_trailer_idx(trailer_idx),
		.o_leader_word(leader_word), .o_trailer_word(trailer_word),
		.o_block_id(block_id), .o_ts_latched(ts_latched)
	);

	u3v_chunk_gen #(.TS_WD(TS_WD), .BID_WD(BID_WD), .IDX_WD(IDX_WD)) u_chunk (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_frame_start(frame_start), .i_image_word(image_word),
		.i_chunk_mode(chunk_mode), .i_fid_en(fid_en), .i_ts_en(ts_en),
		.i_block_id(block_id), .i_ts_latched(ts_latched),
		.i_chunk_idx(chunk_idx),
		.o_chunk_word(chunk_word), .o_chunk_words(chunk_words)
	);

	u3v_frame_ctrl #(.IDX_WD(IDX_WD)) u_ctrl (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_fval(i_fval), .i_data_valid(i_data_valid), .i_data(i_data),
		.i_stream_enable(stream_enable), .i_acq_start(acq_start),
		.i_leader_word(leader_word), .i_trailer_word(trailer_word),
		.i_chunk_word(chunk_word), .i_chunk_words(chunk_words),
		.o_frame_start(frame_start), .o_frame_done(frame_done),
		.o_image_word(image_word),
		.o_leader_idx(leader_idx), .o_trailer_idx(trailer_idx),
		.o_chunk_idx(chunk_idx), .o_state(fmt_state),
		.o_fval(o_fval), .o_data_valid(o_data_valid),
		.o_leader_flag(o_leader_flag), .o_image_flag(o_image_flag),
		.o_chunk_flag(o_chunk_flag), .o_trailer_flag(o_trailer_flag),
		.o_data(o_data)
	);

endmodule

`default_nettype wire

// ==== testbench/u3v_format_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module u3v_format_chk (
	input wire       clk,
	input wire       i_rst_n,
	// section state of the frame controller
	input wire [2:0] i_state,
	// formatted stream of the top level
	input wire       i_stream_fval,
	input wire       i_stream_valid,
	input wire       i_leader_flag,
	input wire       i_image_flag,
	input wire       i_chunk_flag,
	input wire       i_trailer_flag
);

	logic [3:0] flags;

	assign flags = {i_trailer_flag, i_chunk_flag, i_image_flag, i_leader_flag};

	// ------------------------------
	// stream protocol
	// ------------------------------
	// one section per valid word
	a_one_section: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_stream_valid |-> $onehot(flags))
		else $error("section flags not one-hot on a valid word");

	// words only inside a block
	a_valid_in_block: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_stream_valid |-> i_stream_fval)
		else $error("data valid outside of fval");

	// a swallowed frame shows nothing on the stream
	a_skip_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_state == u3v_pkg::SKIP) |-> (!i_stream_fval && !i_stream_valid))
		else $error("stream active while a frame is skipped");

	// sync reset clears the outputs one edge later
	a_reset_quiet: assert property (@(posedge clk)
		!i_rst_n |=> (!i_stream_fval && !i_stream_valid && flags == 4'b0000))
		else $error("stream outputs active during reset");

endmodule

bind u3v_format_top u3v_format_chk u_chk (
	.clk(clk),
	.i_rst_n(i_rst_n),
	.i_state(fmt_state),
	.i_stream_fval(o_fval),
	.i_stream_valid(o_data_valid),
	.i_leader_flag(o_leader_flag),
	.i_image_flag(o_image_flag),
	.i_chunk_flag(o_chunk_flag),
	.i_trailer_flag(o_trailer_flag)
);

`default_nettype wire

// ==== testbench/tb_u3v_format.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_u3v_format;

	localparam int WAIT_LIMIT = 100;
	// section flags as {trailer, chunk, image, leader}
	localparam logic [3:0] F_LEADER  = 4'b0001;
	localparam logic [3:0] F_IMAGE   = 4'b0010;
	localparam logic [3:0] F_CHUNK   = 4'b0100;
	localparam logic [3:0] F_TRAILER = 4'b1000;

	logic        clk;
	logic        i_rst_n;
	logic        i_psel, i_penable, i_pwrite;
	logic [7:0]  i_paddr;
	logic [31:0] i_pwdata;
	logic [31:0] o_prdata;
	logic        o_pready, o_pslverr;
	logic        i_fval, i_data_valid;
	logic [31:0] i_data;
	logic [63:0] i_timestamp;
	logic        o_fval, o_data_valid;
	logic        o_leader_flag, o_image_flag, o_chunk_flag, o_trailer_flag;
	logic [31:0] o_data;
	logic [3:0]  out_flags;

	// expected stream entries as {flags, word}
	logic [35:0] exp_q[$];
	logic [31:0] img_buf[$];
	logic [31:0] rng;
	// register and block id model
	logic [31:0] ctrl_model;
	logic [31:0] pix_model;
	logic [31:0] bid_model;

	assign out_flags = {o_trailer_flag, o_chunk_flag, o_image_flag, o_leader_flag};

	u3v_format_top #(.TS_WD(64), .BID_WD(32), .IDX_WD(4)) dut (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.i_fval(i_fval), .i_data_valid(i_data_valid), .i_data(i_data),
		.i_timestamp(i_timestamp),
		.o_fval(o_fval), .o_data_valid(o_data_valid),
		.o_leader_flag(o_leader_flag), .o_image_flag(o_image_flag),
		.o_chunk_flag(o_chunk_flag), .o_trailer_flag(o_trailer_flag),
		.o_data(o_data)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_word();
		rng = xorshift(rng);
		return rng;
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		assert (got === exp) else begin
			report_fail($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
			$fatal(1, "stopped at first error");
		end
	endtask

	// ------------------------------
	// reference model of one block
	// ------------------------------
	function automatic void build_expected(input logic [31:0] bid, input logic [63:0] ts,
		input logic [31:0] pix, input logic [31:0] ctrl);
		logic [31:0] img_bytes;
		logic [31:0] chunk_bytes;
		img_bytes   = 32'(img_buf.size()) * 32'd4;
		chunk_bytes = 32'h0;
		exp_q.push_back({F_LEADER, u3v_pkg::LEADER_MAGIC});
		exp_q.push_back({F_LEADER, 16'h0, u3v_pkg::LEADER_BYTES});
		exp_q.push_back({F_LEADER, bid});
		exp_q.push_back({F_LEADER, ts[31:0]});
		exp_q.push_back({F_LEADER, ts[63:32]});
		exp_q.push_back({F_LEADER, pix});
		// image words pass straight through
		foreach (img_buf[i])
			exp_q.push_back({F_IMAGE, img_buf[i]});
		if (ctrl[u3v_pkg::CHUNK_MODE_BIT]) begin
			exp_q.push_back({F_CHUNK, u3v_pkg::CHUNK_ID_IMAGE});
			exp_q.push_back({F_CHUNK, img_bytes});
			chunk_bytes = 32'd8;
			if (ctrl[u3v_pkg::FID_EN_BIT]) begin
				exp_q.push_back({F_CHUNK, bid});
				exp_q.push_back({F_CHUNK, 32'h0});
				exp_q.push_back({F_CHUNK, u3v_pkg::CHUNK_ID_FID});
				exp_q.push_back({F_CHUNK, 32'd8});
				chunk_bytes = chunk_bytes + 32'd16;
			end
			if (ctrl[u3v_pkg::TS_EN_BIT]) begin
				exp_q.push_back({F_CHUNK, ts[31:0]});
				exp_q.push_back({F_CHUNK, ts[63:32]});
				exp_q.push_back({F_CHUNK, u3v_pkg::CHUNK_ID_TS});
				exp_q.push_back({F_CHUNK, 32'd8});
				chunk_bytes = chunk_bytes + 32'd16;
			end
		end
		exp_q.push_back({F_TRAILER, u3v_pkg::TRAILER_MAGIC});
		exp_q.push_back({F_TRAILER, 16'h0, u3v_pkg::TRAILER_BYTES});
		exp_q.push_back({F_TRAILER, bid});
		// valid payload is image plus chunk bytes
		exp_q.push_back({F_TRAILER, img_bytes + chunk_bytes});
	endfunction

	// ------------------------------
	// apb master
	// ------------------------------
	task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waited;
		@(posedge clk);
		i_psel    <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite  <= wr;
		i_paddr   <= addr;
		i_pwdata  <= wdata;
		@(posedge clk);
		i_penable <= 1'b1;
		// access phase held until pready
		waited = 0;
		@(negedge clk);
		while (!o_pready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		assert (o_pready) else begin
			report_fail("APB transfer never saw pready");
			$fatal(1, "APB timeout");
		end
		rdata = o_prdata;
		err   = o_pslverr;
		@(posedge clk);
		i_psel    <= 1'b0;
		i_penable <= 1'b0;
		i_pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] rdata;
		logic        err;
		apb_transfer(1'b0, addr, 32'h0, rdata, err);
		check_value(64'(err), 64'h0, "pslverr on a read");
		check_value(64'(rdata), 64'(exp), $sformatf("read of offset %h", addr));
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		apb_transfer(1'b1, addr, data, rdata, err);
		check_value(64'(err), 64'h0, "pslverr on a write");
		// ctrl holds five bits
		if (addr == u3v_pkg::CTRL)
			ctrl_model = data & 32'h1F;
		else if (addr == u3v_pkg::PIXEL_FORMAT)
			pix_model = data;
	endtask

	task automatic apb_expect_error(input logic [7:0] addr, input logic wr);
		logic [31:0] rdata;
		logic        err;
		apb_transfer(wr, addr, 32'hFFFF_FFFF, rdata, err);
		check_value(64'(err), 64'h1, $sformatf("pslverr for offset %h", addr));
		// nothing may have changed
		apb_read(u3v_pkg::CTRL, ctrl_model);
		apb_read(u3v_pkg::PIXEL_FORMAT, pix_model);
	endtask

	// ------------------------------
	// frame source
	// ------------------------------
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			report_fail($sformatf("%0d expected words never came out", exp_q.size()));
			$fatal(1, "stream timeout");
		end
	endtask

	task automatic send_frame(input int nwords);
		logic [63:0] ts;
		logic [31:0] r;
		int          sent;
		ts = {rand_word(), rand_word()};
		img_buf.delete();
		for (int i = 0; i < nwords; i++)
			img_buf.push_back(rand_word());
		// only frames starting with both enables are formatted
		if (ctrl_model[u3v_pkg::STREAM_EN_BIT] && ctrl_model[u3v_pkg::ACQ_START_BIT]) begin
			build_expected(bid_model, ts, pix_model, ctrl_model);
			bid_model = bid_model + 32'd1;
		end
		@(posedge clk);
		i_fval      <= 1'b1;
		i_timestamp <= ts;
		// timestamp moves on once the start edge has latched it
		@(posedge clk);
		i_timestamp <= ~ts;
		// leader time before first image word
		repeat (7) @(posedge clk);
		sent = 0;
		while (sent < nwords) begin
			r = rand_word();
			if (r[1:0] == 2'b00) begin
				// idle cycle with junk data
				i_data_valid <= 1'b0;
				i_data       <= r;
			end else begin
				i_data_valid <= 1'b1;
				i_data       <= img_buf[sent];
				sent++;
			end
			@(posedge clk);
		end
		i_fval       <= 1'b0;
		i_data_valid <= 1'b0;
		wait_drained();
		// fval low gap
		repeat (20) @(posedge clk);
	endtask

	// ------------------------------
	// output comparison
	// ------------------------------
	initial begin : compare_stream
		logic [35:0] exp_word;
		logic        fval_prev;
		logic        rose_prev;
		logic        block_end;
		fval_prev = 1'b0;
		rose_prev = 1'b0;
		block_end = 1'b0;
		// first edge clears the outputs
		@(posedge clk);
		forever begin
			@(negedge clk);
			if (!i_rst_n) begin
				check_value(64'({o_fval, o_data_valid, out_flags}), 64'h0, "outputs in reset");
			end else begin
				// o_fval opens one quiet cycle ahead of a leader
				if (o_fval && !fval_prev) begin
					assert (exp_q.size() != 0 && exp_q[0] == {F_LEADER, u3v_pkg::LEADER_MAGIC})
					else begin
						report_fail("o_fval rose with no block expected");
						$fatal(1, "unexpected block");
					end
					check_value(64'(o_data_valid), 64'h0, "data valid as o_fval rises");
				end
				if (rose_prev)
					check_value(64'(o_data_valid), 64'h1, "leader right after o_fval rise");
				// o_fval drops on the cycle after the last trailer word
				if (block_end)
					check_value(64'(o_fval), 64'h0, "o_fval after the last trailer word");
				else if (fval_prev && !o_fval)
					check_value(64'(o_fval), 64'h1, "o_fval before the last trailer word");
				if (o_data_valid) begin
					assert (exp_q.size() != 0) else begin
						report_fail("output word appeared with no word expected");
						$fatal(1, "unexpected output");
					end
					exp_word = exp_q.pop_front();
					check_value(64'(o_fval), 64'h1, "o_fval on a valid word");
					check_value(64'({out_flags, o_data}), 64'(exp_word), "flags and word");
				end else begin
					check_value(64'(out_flags), 64'h0, "flags without data valid");
				end
				block_end = o_data_valid && out_flags == F_TRAILER
					&& (exp_q.size() == 0 || exp_q[0][35:32] != F_TRAILER);
			end
			rose_prev = o_fval && !fval_prev;
			fval_prev = o_fval;
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin : stimulus
		logic [31:0] r;
		rng          = 32'hc6697581;
		ctrl_model   = 32'h0;
		pix_model    = 32'h0;
		bid_model    = 32'h0;
		i_rst_n      = 1'b0;
		i_psel       = 1'b0;
		i_penable    = 1'b0;
		i_pwrite     = 1'b0;
		i_paddr      = 8'h0;
		i_pwdata     = 32'h0;
		i_fval       = 1'b0;
		i_data_valid = 1'b0;
		i_data       = 32'h0;
		i_timestamp  = 64'h0;
		repeat (10) @(posedge clk);
		i_rst_n <= 1'b1;

		// reset values, bad offsets and the read-only block id
		apb_read(u3v_pkg::CTRL, 32'h0);
		apb_read(u3v_pkg::BLOCK_ID, 32'h0);
		apb_expect_error(8'h0C, 1'b0);
		apb_expect_error(8'h40, 1'b1);
		apb_expect_error(u3v_pkg::BLOCK_ID, 1'b1);
		apb_read(u3v_pkg::BLOCK_ID, 32'h0);

		// chunk mode off
		apb_write(u3v_pkg::PIXEL_FORMAT, 32'h0108_0001);
		apb_write(u3v_pkg::CTRL, 32'h3);
		repeat (3) send_frame(1 + int'(rand_word() % 32'd12));

		// every fid and ts enable combination
		for (int c = 0; c < 4; c++) begin
			apb_write(u3v_pkg::CTRL, 32'h7 | (32'(c) << u3v_pkg::FID_EN_BIT));
			send_frame(1 + int'(rand_word() % 32'd12));
		end

		// random settings and lengths with block id readback
		for (int f = 0; f < 8; f++) begin
			r = rand_word();
			apb_write(u3v_pkg::CTRL, {27'h0, r[4:2], 2'b11});
			apb_write(u3v_pkg::PIXEL_FORMAT, rand_word());
			send_frame(1 + int'(rand_word() % 32'd16));
			apb_read(u3v_pkg::BLOCK_ID, bid_model);
		end

		// stream or acquisition off swallows the frame
		apb_write(u3v_pkg::CTRL, 32'h2);
		send_frame(6);
		apb_write(u3v_pkg::CTRL, 32'h1);
		send_frame(6);
		apb_read(u3v_pkg::BLOCK_ID, bid_model);

		// config writes mid frame apply at the next start
		apb_write(u3v_pkg::CTRL, 32'h1F);
		apb_write(u3v_pkg::PIXEL_FORMAT, 32'h0110_0003);
		fork
			send_frame(10);
			begin
				// format write lands inside the leader, before its last word
				repeat (2) @(posedge clk);
				apb_write(u3v_pkg::PIXEL_FORMAT, 32'h0120_0005);
				apb_write(u3v_pkg::CTRL, 32'h3);
			end
		join
		send_frame(4);
		apb_read(u3v_pkg::BLOCK_ID, bid_model);

		// trailing idle time for stray words
		repeat (20) @(posedge clk);
		if (exp_q.size() != 0) begin
			report_fail("expected words left over at the end");
			$fatal(1, "pending words");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/u3v_pkg.sv
rtl/u3v_apb_regs.sv
rtl/u3v_header_gen.sv
rtl/u3v_chunk_gen.sv
rtl/u3v_frame_ctrl.sv
rtl/u3v_format_top.sv
testbench/u3v_format_chk.sv
testbench/tb_u3v_format.sv

// ==== Makefile ====
TOOL       = verilator
TOP        = tb_u3v_format
FILELIST   = verilog.f
BUILD      = obj_dir
FLAGS      = --binary --timing --assert -Wno-fatal --Mdir $(BUILD)
LINT_FLAGS = --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulation binary is the test result
run: build
	./$(BUILD)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
